//--- source/ExUopPkg.sv
// Micro-op encodings for the execute stage; imported by every module that decodes a micro-op
package ExUopPkg;

	localparam int CC_WIDTH = 2;	// Condition code in the top bits
	localparam int OP_WIDTH = 6;	// Opcode below it

	typedef logic [CC_WIDTH+OP_WIDTH-1:0] uopCmd_t;
	typedef logic [OP_WIDTH-1:0]          uopOp_t;
	typedef logic [CC_WIDTH-1:0]          uopCc_t;
	typedef logic [7:0]                   uopIxt_t;

	// Condition codes, tested against SR.T
	localparam uopCc_t CC_AL = 2'd0;
	localparam uopCc_t CC_NV = 2'd1;
	localparam uopCc_t CC_CT = 2'd2;	// Run if T set
	localparam uopCc_t CC_CF = 2'd3;	// Run if T clear

	localparam uopOp_t UOP_NOP    = 6'h00;
	localparam uopOp_t UOP_INVOP  = 6'h01;
	localparam uopOp_t UOP_LEA    = 6'h02;
	localparam uopOp_t UOP_MOV_RM = 6'h03;	// Store Rm to memory
	localparam uopOp_t UOP_MOV_MR = 6'h04;	// Load memory into Rm
	localparam uopOp_t UOP_PUSH   = 6'h05;
	localparam uopOp_t UOP_POP    = 6'h06;
	localparam uopOp_t UOP_MOV_IR = 6'h07;
	localparam uopOp_t UOP_CONV   = 6'h08;
	localparam uopOp_t UOP_BRA    = 6'h09;
	localparam uopOp_t UOP_BSR    = 6'h0A;
	localparam uopOp_t UOP_JMP    = 6'h0B;
	localparam uopOp_t UOP_JSR    = 6'h0C;
	localparam uopOp_t UOP_SHAD3  = 6'h0D;
	localparam uopOp_t UOP_SHLD3  = 6'h0E;
	localparam uopOp_t UOP_SHADQ3 = 6'h0F;
	localparam uopOp_t UOP_SHLDQ3 = 6'h10;
	localparam uopOp_t UOP_OP_IXT = 6'h11;

	// Extension codes under UOP_OP_IXT, low six bits of the extension byte
	localparam logic [OP_WIDTH-1:0] IXT_NOP   = 6'h00;
	localparam logic [OP_WIDTH-1:0] IXT_CLRT  = 6'h01;
	localparam logic [OP_WIDTH-1:0] IXT_SETT  = 6'h02;
	localparam logic [OP_WIDTH-1:0] IXT_NOTT  = 6'h03;
	localparam logic [OP_WIDTH-1:0] IXT_CLRS  = 6'h04;
	localparam logic [OP_WIDTH-1:0] IXT_SETS  = 6'h05;
	localparam logic [OP_WIDTH-1:0] IXT_MOVT  = 6'h06;
	localparam logic [OP_WIDTH-1:0] IXT_BREAK = 6'h07;

endpackage

//--- source/ExRegPkg.sv
// Register, data, address and memory-opcode types shared by the execute and memory stages
package ExRegPkg;

	typedef logic [5:0]  regId_t;
	typedef logic [63:0] word_t;
	typedef logic [31:0] addr_t;	// Also PC and LR
	typedef logic [32:0] imm_t;		// Bit 32 carries the sign

	// Memory opcode: kind in 4:3, signed load in 2, size in 1:0
	typedef logic [4:0] memOpm_t;
	typedef logic [1:0] memKind_t;

	localparam memKind_t OPM_KIND_IDLE = 2'b00;
	localparam memKind_t OPM_KIND_RD   = 2'b01;
	localparam memKind_t OPM_KIND_WR   = 2'b10;

	localparam logic [1:0] SIZE_Q = 2'd3;	// 8-byte access

	localparam memOpm_t OPM_READY = {OPM_KIND_IDLE, 1'b0, 2'd0};
	localparam memOpm_t OPM_RD_Q  = {OPM_KIND_RD, 1'b0, SIZE_Q};
	localparam memOpm_t OPM_WR_Q  = {OPM_KIND_WR, 1'b0, SIZE_Q};

	// Special register IDs on the writeback ports
	localparam regId_t REG_ZZR = 6'h3F;	// Discard, no write
	localparam regId_t REG_PC  = 6'h3E;	// Branch target

	// SR flag positions
	localparam int SR_T = 0;
	localparam int SR_S = 1;

	// Stack moves one qword per push or pop
	localparam word_t SP_STEP = 64'd8;

endpackage

//--- source/ExShifter.sv
// Combinational barrel shifter for the SHAD/SHLD micro-ops; signed amount picks left or right
`timescale 1ns/1ps

module ExShifter (
	input  ExRegPkg::word_t  value,
	input  logic signed [7:0] amount,	// >0 left, <0 right
	input  logic             arith,		// Sign fill on right shifts
	output logic [31:0]      result32,
	output ExRegPkg::word_t  result64
);

	logic [7:0] leftAmt;
	logic [7:0] rightAmt;
	logic       goRight;

	assign goRight  = amount[7];
	assign leftAmt  = amount;
	assign rightAmt = 8'(-amount);	// -128 gives 128, all bits out

	always_comb begin
		if (!goRight) begin
			result32 = value[31:0] << leftAmt;
			result64 = value << leftAmt;
		end else if (arith) begin
			// Large counts saturate to all sign bits
			result32 = $signed(value[31:0]) >>> rightAmt;
			result64 = $signed(value) >>> rightAmt;
		end else begin
			result32 = value[31:0] >> rightAmt;
			result64 = value >> rightAmt;
		end
	end

endmodule

//--- source/ExConv.sv
// Byte, word and dword sign or zero extension to 64 bits for the CONV micro-op
`timescale 1ns/1ps

module ExConv (
	input  ExRegPkg::word_t value,
	input  logic [2:0]      mode,	// Bit 2 signed, 1:0 size
	output ExRegPkg::word_t result
);

	logic isSigned;
	logic fillByte;
	logic fillWord;
	logic fillDword;

	assign isSigned  = mode[2];
	assign fillByte  = isSigned && value[7];
	assign fillWord  = isSigned && value[15];
	assign fillDword = isSigned && value[31];

	always_comb begin
		case (mode[1:0])
			2'd0:    result = {{56{fillByte}}, value[7:0]};
			2'd1:    result = {{48{fillWord}}, value[15:0]};
			2'd2:    result = {{32{fillDword}}, value[31:0]};
			default: result = value;	// Qword, nothing to extend
		endcase
	end

endmodule

//--- source/ExEx1.sv
// Execute stage 1: condition gating, AGU and per-micro-op result selection, combinational
`timescale 1ns/1ps

module ExEx1 (
	input  ExUopPkg::uopCmd_t  opUCmd,
	input  ExUopPkg::uopIxt_t  opUIxt,
	input  logic               opBraFlush,
	input  ExRegPkg::regId_t   regIdRm,
	input  ExRegPkg::word_t    regValRs,	// Base / shift source
	input  ExRegPkg::word_t    regValRt,	// Index / shift amount
	input  ExRegPkg::word_t    regValRm,	// Store data
	input  ExRegPkg::imm_t     regValImm,
	input  ExRegPkg::addr_t    regValPc,
	input  ExRegPkg::word_t    sr,
	input  ExRegPkg::word_t    sp,
	input  ExRegPkg::addr_t    lr,
	input  logic               memBusy,
	output logic               accept,
	output logic               exHold,
	output ExRegPkg::regId_t   wbId,
	output ExRegPkg::word_t    wbVal,
	output logic               brValid,
	output ExRegPkg::addr_t    brPc,
	output ExRegPkg::word_t    newSr,
	output ExRegPkg::word_t    newSp,
	output ExRegPkg::addr_t    newLr,
	output logic               memStart,
	output ExRegPkg::memOpm_t  memOpm,
	output ExRegPkg::addr_t    memAddr,
	output ExRegPkg::word_t    memData,
	output ExRegPkg::regId_t   memLoadId
);
	import ExUopPkg::*;
	import ExRegPkg::*;

	uopCc_t      cc;
	logic        opEnable;
	uopOp_t      gatedOp;
	logic        invalidOp;
	logic        memOp;
	logic        shiftArith;
	addr_t       aguAddr;
	logic [31:0] shift32;
	word_t       shift64;
	word_t       convVal;

	assign cc = opUCmd[OP_WIDTH +: CC_WIDTH];

	// Index scaled by access size
	assign aguAddr    = regValRs[31:0] + (regValRt[31:0] << opUIxt[1:0]);
	assign shiftArith = (gatedOp == UOP_SHAD3) || (gatedOp == UOP_SHADQ3);

	ExShifter shifter_i (
		.value    (regValRs),
		.amount   (regValRt[7:0]),
		.arith    (shiftArith),
		.result32 (shift32),
		.result64 (shift64)
	);

	ExConv conv_i (
		.value  (regValRs),
		.mode   (opUIxt[2:0]),
		.result (convVal)
	);

	always_comb begin
		case (cc)
			CC_AL: opEnable = 1'b1;
			CC_NV: opEnable = 1'b0;
			CC_CT: opEnable = sr[SR_T];
			CC_CF: opEnable = !sr[SR_T];
		endcase
		// Flushed or failed ops turn into a NOP
		gatedOp = (opEnable && !opBraFlush) ? opUCmd[OP_WIDTH-1:0] : UOP_NOP;
	end

	always_comb begin
		wbId      = REG_ZZR;
		wbVal     = regValRs;
		brValid   = 1'b0;
		brPc      = aguAddr;
		newSr     = sr;
		newSp     = sp;
		newLr     = lr;
		memOp     = 1'b0;
		memOpm    = OPM_READY;
		memAddr   = aguAddr;
		memData   = regValRm;
		memLoadId = REG_ZZR;
		invalidOp = 1'b0;

		case (gatedOp)
			UOP_NOP: begin
			end
			UOP_LEA: begin
				wbId  = regIdRm;
				wbVal = {32'h0, aguAddr};
			end
			UOP_MOV_RM: begin
				memOp  = 1'b1;
				memOpm = {OPM_KIND_WR, opUIxt[2:0]};
			end
			UOP_MOV_MR: begin
				memOp     = 1'b1;
				memOpm    = {OPM_KIND_RD, opUIxt[2:0]};
				memLoadId = regIdRm;
			end
			UOP_PUSH: begin
				newSp   = sp - SP_STEP;	// Predecrement
				memAddr = newSp[31:0];
				memData = regValRs;
				memOpm  = OPM_WR_Q;
				memOp   = 1'b1;
			end
			UOP_POP: begin
				newSp     = sp + SP_STEP;
				memAddr   = sp[31:0];
				memOpm    = OPM_RD_Q;
				memLoadId = regIdRm;
				memOp     = 1'b1;
			end
			UOP_MOV_IR: begin
				wbId = regIdRm;
				case (opUIxt[1:0])
					2'd0:    wbVal = {{31{regValImm[32]}}, regValImm};
					2'd1:    wbVal = {regValRs[55:0], regValImm[7:0]};
					2'd2:    wbVal = {regValRs[47:0], regValImm[15:0]};
					default: wbVal = {regValRs[31:0], regValImm[31:0]};
				endcase
			end
			UOP_CONV: begin
				wbId  = regIdRm;
				wbVal = convVal;
			end
			UOP_BRA: brValid = 1'b1;	// Target from AGU
			UOP_BSR: begin
				brValid = 1'b1;
				newLr   = regValPc;
			end
			UOP_JMP: begin
				brValid = 1'b1;
				brPc    = regValRs[31:0];
			end
			UOP_JSR: begin
				brValid = 1'b1;
				brPc    = regValRs[31:0];
				newLr   = regValPc;
			end
			UOP_SHAD3: begin
				wbId  = regIdRm;
				wbVal = {{32{shift32[31]}}, shift32};
			end
			UOP_SHLD3: begin
				wbId  = regIdRm;
				wbVal = {32'h0, shift32};
			end
			UOP_SHADQ3, UOP_SHLDQ3: begin
				wbId  = regIdRm;
				wbVal = shift64;
			end
			UOP_OP_IXT: begin
				case (opUIxt[OP_WIDTH-1:0])
					IXT_NOP: begin
					end
					IXT_CLRT: newSr[SR_T] = 1'b0;
					IXT_SETT: newSr[SR_T] = 1'b1;
					IXT_NOTT: newSr[SR_T] = !sr[SR_T];
					IXT_CLRS: newSr[SR_S] = 1'b0;
					IXT_SETS: newSr[SR_S] = 1'b1;
					IXT_MOVT: begin
						wbId  = regIdRm;
						wbVal = {63'h0, sr[SR_T]};
					end
					IXT_BREAK: invalidOp = 1'b1;
					default:   invalidOp = 1'b1;	// Unhandled extension
				endcase
			end
			UOP_INVOP: invalidOp = 1'b1;
			default:   invalidOp = 1'b1;
		endcase
	end

	// Bad ops stall in place, as does an access in flight
	assign exHold   = invalidOp || memBusy;
	assign accept   = (gatedOp != UOP_NOP) && !exHold;
	assign memStart = accept && memOp;

endmodule

//--- source/ExMemStage.sv
// Second stage: registers writeback and branch results and runs the four-phase memory access
`timescale 1ns/1ps

module ExMemStage (
	input  logic               clock,
	input  logic               arstN,
	input  logic               accept,
	input  ExRegPkg::regId_t   wbId,
	input  ExRegPkg::word_t    wbVal,
	input  logic               brValid,
	input  ExRegPkg::addr_t    brPc,
	input  logic               memStart,
	input  ExRegPkg::memOpm_t  startOpm,
	input  ExRegPkg::addr_t    startAddr,
	input  ExRegPkg::word_t    memData,
	input  ExRegPkg::regId_t   memLoadId,
	input  logic               memAck,
	input  ExRegPkg::word_t    memDataIn,
	output ExRegPkg::regId_t   regIdRn1,
	output ExRegPkg::word_t    regValRn1,
	output ExRegPkg::regId_t   regIdCn1,
	output ExRegPkg::word_t    regValCn1,
	output logic               memBusy,
	output logic               memReq,
	output ExRegPkg::addr_t    memAddr,
	output ExRegPkg::memOpm_t  memOpm,
	output ExRegPkg::word_t    memDataOut
);
	import ExRegPkg::*;

	typedef enum logic [1:0] {IDLE, REQ, WAITLOW, LOADWB} memState_t;

	memState_t state;
	memState_t stateNext;
	regId_t    loadId;
	logic      isRead;
	logic      loadDone;

	assign isRead   = (memOpm[4:3] == OPM_KIND_RD);
	assign loadDone = (state == REQ) && memAck && isRead;	// Read data valid with ack
	assign memReq   = (state == REQ);
	assign memBusy  = (state != IDLE);

	always_comb begin
		stateNext = state;
		case (state)
			IDLE:    if (memStart) stateNext = REQ;
			REQ:     if (memAck) stateNext = isRead ? LOADWB : WAITLOW;
			LOADWB:  stateNext = memAck ? WAITLOW : IDLE;
			WAITLOW: if (!memAck) stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state    <= IDLE;
			regIdRn1 <= REG_ZZR;
			regIdCn1 <= REG_ZZR;
			memOpm   <= OPM_READY;
		end else begin
			state <= stateNext;
			if (loadDone)
				regIdRn1 <= loadId;
			else
				regIdRn1 <= accept ? wbId : REG_ZZR;
			regIdCn1 <= (accept && brValid) ? REG_PC : REG_ZZR;
			if (memStart)
				memOpm <= startOpm;
		end
	end

	// Data side, qualified by the IDs above
	always_ff @(posedge clock) begin
		regValRn1 <= loadDone ? memDataIn : wbVal;
		regValCn1 <= {32'h0, brPc};
		if (memStart) begin
			memAddr    <= startAddr;
			memDataOut <= memData;
			loadId     <= memLoadId;
		end
	end

endmodule

//--- source/ExSprFile.sv
// Special registers SR, SP and LR, loaded from the execute stage on each accepted micro-op
`timescale 1ns/1ps

module ExSprFile (
	input  logic            clock,
	input  logic            arstN,
	input  logic            accept,
	input  ExRegPkg::word_t newSr,
	input  ExRegPkg::word_t newSp,
	input  ExRegPkg::addr_t newLr,
	output ExRegPkg::word_t sr,
	output ExRegPkg::word_t sp,
	output ExRegPkg::addr_t lr
);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			sr <= '0;
			sp <= '0;
			lr <= '0;
		end else if (accept) begin
			// Untouched fields come back unchanged from EX1
			sr <= newSr;
			sp <= newSp;
			lr <= newLr;
		end
	end

endmodule

//--- source/ExUnit.sv
// Execute unit top: connects EX1, the memory stage and the special registers to the pipeline
`timescale 1ns/1ps

module ExUnit (
	input  logic               clock,
	input  logic               arstN,
	input  ExUopPkg::uopCmd_t  opUCmd,
	input  ExUopPkg::uopIxt_t  opUIxt,
	input  logic               opBraFlush,
	input  ExRegPkg::regId_t   regIdRm,
	input  ExRegPkg::word_t    regValRs,
	input  ExRegPkg::word_t    regValRt,
	input  ExRegPkg::word_t    regValRm,
	input  ExRegPkg::imm_t     regValImm,
	input  ExRegPkg::addr_t    regValPc,
	output logic               exHold,
	output ExRegPkg::regId_t   regIdRn1,
	output ExRegPkg::word_t    regValRn1,
	output ExRegPkg::regId_t   regIdCn1,
	output ExRegPkg::word_t    regValCn1,
	output ExRegPkg::word_t    sr,
	output ExRegPkg::word_t    sp,
	output ExRegPkg::addr_t    lr,
	output logic               memReq,
	input  logic               memAck,
	output ExRegPkg::addr_t    memAddr,
	output ExRegPkg::memOpm_t  memOpm,
	output ExRegPkg::word_t    memDataOut,
	input  ExRegPkg::word_t    memDataIn
);
	import ExRegPkg::*;

	logic    accept;
	logic    brValid;
	logic    memStart;
	logic    memBusy;
	regId_t  wbId;
	regId_t  memLoadId;
	word_t   wbVal;
	word_t   exMemData;
	word_t   newSr;
	word_t   newSp;
	addr_t   newLr;
	addr_t   brPc;
	addr_t   exMemAddr;
	memOpm_t exMemOpm;

	ExEx1 ex1_i (
		.opUCmd, .opUIxt, .opBraFlush, .regIdRm,
		.regValRs, .regValRt, .regValRm, .regValImm, .regValPc,
		.sr, .sp, .lr, .memBusy,
		.accept, .exHold, .wbId, .wbVal, .brValid, .brPc,
		.newSr, .newSp, .newLr, .memStart,
		.memOpm    (exMemOpm),
		.memAddr   (exMemAddr),
		.memData   (exMemData),
		.memLoadId
	);

	ExMemStage mem_i (
		.clock, .arstN, .accept, .wbId, .wbVal, .brValid, .brPc,
		.memStart,
		.startOpm  (exMemOpm),
		.startAddr (exMemAddr),
		.memData   (exMemData),
		.memLoadId, .memAck, .memDataIn,
		.regIdRn1, .regValRn1, .regIdCn1, .regValCn1,
		.memBusy, .memReq, .memAddr, .memOpm, .memDataOut
	);

	ExSprFile spr_i (
		.clock, .arstN, .accept,
		.newSr, .newSp, .newLr,
		.sr, .sp, .lr
	);

endmodule

//--- tests/ExUnitTb.sv
// Self-checking testbench for ExUnit; plays decode stage and memory, run from tb.f as top ExUnitTb
`timescale 1ns/1ps

module ExUnitTb;
	import ExUopPkg::*;
	import ExRegPkg::*;

	localparam int NUM_TESTS  = 7;
	localparam int WAIT_LIMIT = 40;	// Cycles before a handshake counts as stuck

	logic    clock;
	logic    arstN;
	uopCmd_t opUCmd;
	uopIxt_t opUIxt;
	logic    opBraFlush;
	regId_t  regIdRm;
	word_t   regValRs;
	word_t   regValRt;
	word_t   regValRm;
	imm_t    regValImm;
	addr_t   regValPc;
	logic    exHold;
	regId_t  regIdRn1;
	word_t   regValRn1;
	regId_t  regIdCn1;
	word_t   regValCn1;
	word_t   sr;
	word_t   sp;
	addr_t   lr;
	logic    memReq;
	logic    memAck;
	addr_t   memAddr;
	memOpm_t memOpm;
	word_t   memDataOut;
	word_t   memDataIn;

	integer seed = 49;
	integer ackSeed = 49;	// Separate stream for the responder
	int     errors = 0;
	int     errorsBefore = 0;
	int     testsRun = 0;
	int     failedTests = 0;
	word_t  mem [16];
	logic [OP_WIDTH-1:0] flagSeq [7] = '{IXT_SETT, IXT_NOTT, IXT_MOVT, IXT_NOTT,
		IXT_SETS, IXT_MOVT, IXT_CLRS};

	ExUnit dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		repeat (NUM_TESTS * 200) @(posedge clock);
		$display("Watchdog expired after %0d cycles", NUM_TESTS * 200);
		$display("Some tests failed");
		$finish;
	end

	// Memory model, answers each request after 0 to 3 cycles
	initial begin
		int i;
		memAck    = 1'b0;
		memDataIn = '0;
		for (i = 0; i < 16; i++)
			mem[i] = {32'hC0DE0000 | i, 32'hFFFFFFFF - i};
		forever begin
			@(negedge clock);
			if (memReq && !memAck) begin
				repeat ({$random(ackSeed)} % 4) @(negedge clock);
				if (memOpm[4:3] == OPM_KIND_WR)
					mem[memAddr[6:3]] = memDataOut;
				else
					memDataIn = mem[memAddr[6:3]];
				memAck = 1'b1;
				while (memReq)
					@(negedge clock);
				repeat ({$random(ackSeed)} % 4) @(negedge clock);
				memAck = 1'b0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!arstN) $rose(memReq) |-> !$past(memAck))
	else begin
		$display("memReq rose while memAck was still high");
		errors++;
	end
	assert property (@(posedge clock) disable iff (!arstN) $fell(memReq) |-> $past(memAck))
	else begin
		$display("memReq dropped before memAck was seen");
		errors++;
	end
	assert property (@(posedge clock) disable iff (!arstN) $fell(memAck) |-> !memReq)
	else begin
		$display("memAck dropped while memReq was still high");
		errors++;
	end
	assert property (@(posedge clock) disable iff (!arstN)
		memReq && $past(memReq) |-> $stable(memAddr) && $stable(memOpm) && $stable(memDataOut))
	else begin
		$display("Request fields changed while memReq was high");
		errors++;
	end
	assert property (@(posedge clock) disable iff (!arstN) memReq |-> exHold)
	else begin
		$display("exHold was low during a memory access");
		errors++;
	end

	task automatic checkValue(input string name, input word_t got, input word_t exp);
		assert (got === exp)
		else begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors == errorsBefore) begin
			$display("PASS %s", name);
		end else begin
			failedTests++;
			$display("FAIL %s, %0d errors", name, errors - errorsBefore);
		end
		errorsBefore = errors;
	endtask

	// Present one micro-op on a falling edge and return one cycle after it is taken
	task automatic execute(input uopCmd_t cmd, input uopIxt_t ixt, input regId_t rm,
			input word_t rs = '0, input word_t rt = '0, input word_t rmVal = '0,
			input imm_t imm = '0, input addr_t pc = '0);
		int waited;
		waited    = 0;
		opUCmd    = cmd;
		opUIxt    = ixt;
		regIdRm   = rm;
		regValRs  = rs;
		regValRt  = rt;
		regValRm  = rmVal;
		regValImm = imm;
		regValPc  = pc;
		#1;
		while (exHold && waited < WAIT_LIMIT) begin
			@(negedge clock);
			#1;
			waited++;
		end
		if (exHold) begin
			$display("Micro-op %h was never taken, exHold stayed high", cmd);
			errors++;
		end
		@(negedge clock);
		opUCmd     = {CC_AL, UOP_NOP};
		opBraFlush = 1'b0;
	endtask

	// Data is the store data for writes and the expected load value for reads
	task automatic memAccess(input uopCmd_t cmd, input regId_t rm, input word_t rs,
			input word_t rt, input word_t rmVal, input addr_t addr, input memOpm_t opm,
			input word_t data);
		int waited;
		int loads;
		waited = 0;
		loads  = 0;
		execute(cmd, {5'b0, opm[2:0]}, rm, rs, rt, rmVal);
		if (!memReq) begin
			$display("No memory request after micro-op %h", cmd);
			errors++;
		end else begin
			checkValue("memAddr", memAddr, addr);
			checkValue("memOpm", memOpm, opm);
			if (opm[4:3] == OPM_KIND_WR)
				checkValue("memDataOut", memDataOut, data);
		end
		while (exHold && waited < WAIT_LIMIT) begin
			if (opm[4:3] == OPM_KIND_RD && regIdRn1 == rm) begin
				loads++;
				checkValue("regValRn1", regValRn1, data);
			end
			@(negedge clock);
			waited++;
		end
		if (exHold) begin
			$display("Memory access never finished, exHold stuck high");
			errors++;
		end else if (opm[4:3] == OPM_KIND_RD && loads != 1) begin
			$display("Load data reached its register %0d times instead of once", loads);
			errors++;
		end
	endtask

	function automatic word_t movIrRef(input logic [1:0] mode, input word_t rs, input imm_t imm);
		case (mode)
			2'd0:    return imm[32] ? {31'h7FFFFFFF, imm} : {31'h0, imm};
			2'd1:    return (rs << 8) | imm[7:0];
			2'd2:    return (rs << 16) | imm[15:0];
			default: return (rs << 32) | imm[31:0];
		endcase
	endfunction

	// One bit per step; the 32-bit forms start from the extended low word
	function automatic word_t shiftRef(input uopOp_t op, input word_t v, input int n);
		word_t x;
		logic  quad;
		logic  arith;
		quad  = (op == UOP_SHADQ3) || (op == UOP_SHLDQ3);
		arith = (op == UOP_SHAD3) || (op == UOP_SHADQ3);
		x = quad ? v : {{32{arith & v[31]}}, v[31:0]};
		repeat (n < 0 ? -n : n)
			x = (n < 0) ? {arith & x[63], x[63:1]} : x << 1;
		if (!quad)
			x = {{32{arith & x[31]}}, x[31:0]};
		return x;
	endfunction

	function automatic word_t convRef(input logic [2:0] mode, input word_t v);
		int    bits;
		int    i;
		word_t r;
		bits = 8 << mode[1:0];
		r = v;
		for (i = bits; i < 64; i++)
			r[i] = mode[2] & v[bits-1];
		return r;
	endfunction

	initial begin
		word_t  rs;
		word_t  rt;
		word_t  data;
		word_t  srExp;
		word_t  spStart;
		imm_t   imm;
		addr_t  pc;
		addr_t  tgt;
		uopOp_t op;
		int     i;
		logic signed [7:0] amt;
		opUCmd     = {CC_AL, UOP_NOP};
		opUIxt     = '0;
		opBraFlush = 1'b0;
		regIdRm    = REG_ZZR;
		regValRs   = '0;
		regValRt   = '0;
		regValRm   = '0;
		regValImm  = '0;
		regValPc   = '0;
		arstN      = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		@(negedge clock);

		checkValue("exHold", exHold, 0);
		checkValue("memReq", memReq, 0);
		checkValue("regIdRn1", regIdRn1, REG_ZZR);
		checkValue("regIdCn1", regIdCn1, REG_ZZR);
		checkValue("sr", sr, 0);
		checkValue("sp", sp, 0);
		checkValue("lr", lr, 0);
		endTest("reset values");

		for (i = 0; i < 4; i++) begin
			rs  = {$random(seed), $random(seed)};
			imm = imm_t'({$random(seed), $random(seed)});
			execute({CC_AL, UOP_MOV_IR}, uopIxt_t'(i), 6'd5, rs, '0, '0, imm);
			checkValue("regIdRn1", regIdRn1, 6'd5);
			checkValue("regValRn1", regValRn1, movIrRef(2'(i), rs, imm));
		end
		for (i = 0; i < 8; i++) begin
			op  = uopOp_t'(UOP_SHAD3 + i % 4);	// SHAD3, SHLD3, SHADQ3, SHLDQ3
			amt = 8'($random(seed) % 21);
			rs  = {$random(seed), $random(seed)};
			execute({CC_AL, op}, 8'h00, 6'd6, rs, word_t'(amt));
			checkValue("regIdRn1", regIdRn1, 6'd6);
			checkValue("regValRn1", regValRn1, shiftRef(op, rs, amt));
		end
		@(negedge clock);
		checkValue("regIdRn1", regIdRn1, REG_ZZR);	// Only one cycle of writeback
		endTest("immediate loads and shifts");

		execute({CC_AL, UOP_OP_IXT}, {2'b0, IXT_SETT}, REG_ZZR);
		checkValue("sr.T", sr[SR_T], 1);
		execute({CC_CT, UOP_MOV_IR}, 8'h00, 6'd7, '0, '0, '0, 33'h55);
		checkValue("regIdRn1", regIdRn1, 6'd7);
		execute({CC_CF, UOP_MOV_IR}, 8'h00, 6'd8, '0, '0, '0, 33'h55);
		checkValue("regIdRn1", regIdRn1, REG_ZZR);
		execute({CC_AL, UOP_OP_IXT}, {2'b0, IXT_CLRT}, REG_ZZR);
		checkValue("sr.T", sr[SR_T], 0);
		execute({CC_CF, UOP_MOV_IR}, 8'h00, 6'd8, '0, '0, '0, 33'h55);
		checkValue("regIdRn1", regIdRn1, 6'd8);
		execute({CC_CT, UOP_MOV_IR}, 8'h00, 6'd7, '0, '0, '0, 33'h55);
		checkValue("regIdRn1", regIdRn1, REG_ZZR);
		execute({CC_NV, UOP_MOV_IR}, 8'h00, 6'd7, '0, '0, '0, 33'h55);
		checkValue("regIdRn1", regIdRn1, REG_ZZR);
		srExp = sr;
		opBraFlush = 1'b1;
		execute({CC_AL, UOP_OP_IXT}, {2'b0, IXT_SETS}, REG_ZZR);
		checkValue("sr", sr, srExp);
		opBraFlush = 1'b1;
		execute({CC_AL, UOP_MOV_IR}, 8'h00, 6'd9, '0, '0, '0, 33'h55);
		checkValue("regIdRn1", regIdRn1, REG_ZZR);
		endTest("condition codes and flush");

		for (i = 0; i < 4; i++) begin
			rs   = {$random(seed), $random(seed)};
			rt   = {$random(seed), $random(seed)};
			pc   = $random(seed);
			op   = uopOp_t'(UOP_BRA + i);	// BRA, BSR, JMP, JSR
			data = {32'h0, lr};
			execute({CC_AL, op}, uopIxt_t'(i), REG_ZZR, rs, rt, '0, '0, pc);
			if (op == UOP_BRA || op == UOP_BSR)
				tgt = rs[31:0] + rt[31:0] * (32'd1 << i);
			else
				tgt = rs[31:0];
			checkValue("regIdCn1", regIdCn1, REG_PC);
			checkValue("regValCn1", regValCn1, {32'h0, tgt});
			checkValue("lr", lr, (op == UOP_BSR || op == UOP_JSR) ? pc : data[31:0]);
		end
		endTest("branches and calls");

		for (i = 1; i < 4; i++) begin
			data = {$random(seed), $random(seed)};
			memAccess({CC_AL, UOP_MOV_RM}, REG_ZZR, 64'h100, word_t'(i), data,
				32'h100 + 8 * i, OPM_WR_Q, data);
			spStart = sp;
			memAccess({CC_AL, UOP_PUSH}, REG_ZZR, ~data, '0, '0, spStart[31:0] - 32'd8,
				OPM_WR_Q, ~data);
			checkValue("sp", sp, spStart - 64'd8);
			memAccess({CC_AL, UOP_POP}, 6'd9, '0, '0, '0, spStart[31:0] - 32'd8,
				OPM_RD_Q, ~data);
			checkValue("sp", sp, spStart);
			memAccess({CC_AL, UOP_MOV_MR}, 6'd10, 64'h100, word_t'(i), '0,
				32'h100 + 8 * i, OPM_RD_Q, data);
		end
		endTest("memory handshake");

		srExp = sr;
		for (i = 0; i < 3; i++) begin
			opUCmd  = (i == 0) ? {CC_AL, UOP_INVOP} : {CC_AL, UOP_OP_IXT};
			opUIxt  = (i == 1) ? {2'b0, IXT_BREAK} : 8'h3A;	// Last one is unknown
			regIdRm = 6'd11;
			repeat (4) begin
				#1;
				checkValue("exHold", exHold, 1);
				checkValue("memReq", memReq, 0);
				checkValue("regIdRn1", regIdRn1, REG_ZZR);
				@(negedge clock);
			end
			opUCmd = {CC_AL, UOP_NOP};
			#1;
			checkValue("exHold", exHold, 0);
			@(negedge clock);
		end
		checkValue("sr", sr, srExp);
		endTest("hold on invalid micro-ops");

		for (i = 0; i < 8; i++) begin
			rs = {$random(seed), $random(seed)};
			execute({CC_AL, UOP_CONV}, uopIxt_t'(i), 6'd12, rs);
			checkValue("regValRn1", regValRn1, convRef(3'(i), rs));
		end
		srExp = sr;
		for (i = 0; i < 7; i++) begin
			execute({CC_AL, UOP_OP_IXT}, {2'b0, flagSeq[i]}, 6'd13);
			case (flagSeq[i])
				IXT_SETT: srExp[SR_T] = 1'b1;
				IXT_NOTT: srExp[SR_T] = !srExp[SR_T];
				IXT_SETS: srExp[SR_S] = 1'b1;
				IXT_CLRS: srExp[SR_S] = 1'b0;
				default: begin
					checkValue("regIdRn1", regIdRn1, 6'd13);
					checkValue("regValRn1", regValRn1, {63'h0, srExp[SR_T]});
				end
			endcase
			checkValue("sr", sr, srExp);
		end
		endTest("flags and extension");

		$display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, failedTests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- tb.f
source/ExUopPkg.sv
source/ExRegPkg.sv
source/ExShifter.sv
source/ExConv.sv
source/ExEx1.sv
source/ExMemStage.sv
source/ExSprFile.sv
source/ExUnit.sv
tests/ExUnitTb.sv

//--- Bender.yml
package:
  name: ex_unit

sources:
  - source/ExUopPkg.sv
  - source/ExRegPkg.sv
  - source/ExShifter.sv
  - source/ExConv.sv
  - source/ExEx1.sv
  - source/ExMemStage.sv
  - source/ExSprFile.sv
  - source/ExUnit.sv
  - target: test
    files:
      - tests/ExUnitTb.sv
